// File: run_sim.sh
#!/usr/bin/env bash
# build and run the io_fabric testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --assert --top-module tb_io_fabric -Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_io_fabric" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: sim/tb_io_fabric.sv
`timescale 1ns/10ps

`include "io_settings.svh"

module tb_io_fabric
    import io_pkg::*;
();

    localparam int ACK_TIMEOUT = 8;
    localparam int IRQ_TIMEOUT = 400;
    localparam int POLL_LIMIT  = 100;

    logic      clk;
    logic      arst_n_i;
    bus_addr_t adr_i;
    bus_data_t dat_i;
    logic      we_i;
    logic      stb_i;
    bus_data_t dat_o;
    logic      ack_o;
    logic      irq_o;

    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    string       cur_test;
    logic [15:0] reload_shadow [`TIMER_COUNT];

    io_fabric UUT (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .adr_i    (adr_i),
        .dat_i    (dat_i),
        .we_i     (we_i),
        .stb_i    (stb_i),
        .dat_o    (dat_o),
        .ack_o    (ack_o),
        .irq_o    (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    bus_ack_single: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_o |=> !ack_o
    ) else begin
        $display("%s: bus acknowledge stayed high for two cycles", cur_test);
        test_errors++;
    end

    bus_ack_after_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_o |-> $past(stb_i)
    ) else begin
        $display("%s: bus acknowledge without a strobe in the cycle before", cur_test);
        test_errors++;
    end

    function automatic bus_addr_t timer_addr(input int dev, input logic [2:0] offset);
        timer_addr = {`IO_WINDOW, 3'(dev), 5'b0, offset};
    endfunction

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, test_errors);
        end
    endtask

    task automatic check_data(input string what, input bus_data_t expected,
                              input bus_data_t actual);
        assert (actual == expected) else begin
            $display("Mismatch in %s, %s: expected 0x%02h, actual 0x%02h",
                     cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_count(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Mismatch in %s, %s: expected %0d, actual %0d",
                     cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    // starts and returns 1 ns after a rising edge
    task automatic bus_access(input bus_addr_t addr, input logic write,
                              input bus_data_t wdata, output bus_data_t rdata);
        int waited;
        rdata = '0;
        adr_i = addr;
        dat_i = wdata;
        we_i  = write;
        stb_i = 1'b1;
        @(posedge clk);
        #1;
        waited = 1;
        while (!ack_o && waited < ACK_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (ack_o) begin
            rdata = dat_o;
            check_count("acknowledge latency", 1, waited);
        end else begin
            $display("%s: no acknowledge from address %h after %0d cycles",
                     cur_test, addr, waited);
            test_errors++;
        end
        stb_i = 1'b0;
        we_i  = 1'b0;
        @(posedge clk);
        #1;
        assert (!ack_o) else begin
            $display("%s: acknowledge at address %h did not fall after one cycle",
                     cur_test, addr);
            test_errors++;
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t unused;
        bus_access(addr, 1'b1, data, unused);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        bus_access(addr, 1'b0, '0, data);
    endtask

    task automatic read_expect(input bus_addr_t addr, input bus_data_t expected,
                               input string what);
        bus_data_t rd;
        bus_read(addr, rd);
        check_data(what, expected, rd);
    endtask

    task automatic set_reload(input int dev, input logic [15:0] value);
        bus_write(timer_addr(dev, RELOAD_LO), value[7:0]);
        bus_write(timer_addr(dev, RELOAD_HI), value[15:8]);
        reload_shadow[dev] = value;
    endtask

    task automatic wait_irq(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (irq_o != level && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (irq_o != level) begin
            $display("%s: irq_o did not go to %0b within %0d cycles", cur_test, level, limit);
            test_errors++;
        end
    endtask

    task automatic wait_pending(input int dev, input int limit);
        bus_data_t rd;
        int        polls;
        polls = 0;
        bus_read(timer_addr(dev, STATUS), rd);
        while (!rd[0] && polls < limit) begin
            bus_read(timer_addr(dev, STATUS), rd);
            polls++;
        end
        if (!rd[0]) begin
            $display("%s: timer %0d never set pending within %0d polls", cur_test, dev, limit);
            test_errors++;
        end
    endtask

    // every timer except busy_dev must be stopped and clear
    task automatic check_idle(input int busy_dev);
        for (int t = 0; t < `TIMER_COUNT; t++) begin
            if (t != busy_dev) begin
                read_expect(timer_addr(t, STATUS), 8'h00, "idle timer status");
                read_expect(timer_addr(t, COUNT_LO), 8'h00, "idle timer count low");
                read_expect(timer_addr(t, COUNT_HI), 8'h00, "idle timer count high");
            end
        end
    endtask

    initial begin
        logic [15:0] value;
        int          cycles;
        int          period;
        bus_addr_t   miss_addr [3];
        void'($urandom(32'hb7f3_2746));
        arst_n_i     = 1'b0;
        adr_i        = '0;
        dat_i        = '0;
        we_i         = 1'b0;
        stb_i        = 1'b0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_test     = "reset";
        for (int t = 0; t < `TIMER_COUNT; t++) begin
            reload_shadow[t] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        @(posedge clk);
        #1;

        start_test("register access");
        for (int t = 0; t < `TIMER_COUNT; t++) begin
            value = 16'($urandom);
            set_reload(t, value);
            read_expect(timer_addr(t, RELOAD_LO), value[7:0], "reload low");
            read_expect(timer_addr(t, RELOAD_HI), value[15:8], "reload high");
            read_expect(timer_addr(t, 3'd6), 8'h00, "offset 6");
            read_expect(timer_addr(t, 3'd7), 8'h00, "offset 7");
        end
        end_test();

        start_test("one-shot expiry");
        value = 16'(4 + $urandom % 16);
        set_reload(0, value);
        bus_write(timer_addr(0, CTRL), 8'h05);
        wait_irq(1'b1, IRQ_TIMEOUT, cycles);
        check_count("cycles to expiry", int'(value), cycles);
        read_expect(timer_addr(0, STATUS), 8'h01, "status");
        read_expect(timer_addr(0, CTRL), 8'h04, "ctrl");
        read_expect(timer_addr(0, COUNT_LO), 8'h00, "count low");
        read_expect(timer_addr(0, COUNT_HI), 8'h00, "count high");
        end_test();

        start_test("interrupt clear and mask");
        bus_write(timer_addr(0, STATUS), 8'h01);
        wait_irq(1'b0, 2, cycles);
        read_expect(timer_addr(0, STATUS), 8'h00, "status after clear");
        set_reload(1, 16'(4 + $urandom % 16));
        bus_write(timer_addr(1, CTRL), 8'h01);
        wait_pending(1, POLL_LIMIT);
        check_count("irq_o with interrupt masked", 0, int'(irq_o));
        bus_write(timer_addr(1, STATUS), 8'h01);
        end_test();

        // before auto-reload, which leaves timer 3 with a nonzero count
        start_test("channel independence");
        set_reload(2, 16'(32 + $urandom % 32));
        bus_write(timer_addr(2, CTRL), 8'h01);
        check_idle(2);
        wait_pending(2, POLL_LIMIT);
        check_idle(2);
        bus_write(timer_addr(2, STATUS), 8'h01);
        end_test();

        start_test("auto-reload");
        value = 16'(16 + $urandom % 32);
        set_reload(3, value);
        bus_write(timer_addr(3, CTRL), 8'h07);
        wait_irq(1'b1, IRQ_TIMEOUT, cycles);
        // clear write takes two cycles on the bus
        bus_write(timer_addr(3, STATUS), 8'h01);
        period = 2;
        wait_irq(1'b0, 4, cycles);
        period += cycles;
        wait_irq(1'b1, IRQ_TIMEOUT, cycles);
        period += cycles;
        check_count("reload period", int'(value), period);
        read_expect(timer_addr(3, CTRL), 8'h07, "ctrl after reload");
        bus_write(timer_addr(3, CTRL), 8'h00);
        bus_write(timer_addr(3, STATUS), 8'h01);
        wait_irq(1'b0, 4, cycles);
        end_test();

        start_test("unmapped access");
        miss_addr[0] = 32'h0000_0101;
        miss_addr[1] = {`IO_WINDOW, 3'(`TIMER_COUNT), 8'h01};
        miss_addr[2] = {`IO_WINDOW, 3'd7, 8'h01};
        for (int i = 0; i < 3; i++) begin
            read_expect(miss_addr[i], `IO_MISS_DATA, "miss read data");
            bus_write(miss_addr[i], 8'h5A);
        end
        for (int t = 0; t < `TIMER_COUNT; t++) begin
            read_expect(timer_addr(t, RELOAD_LO), reload_shadow[t][7:0], "reload low kept");
            read_expect(timer_addr(t, RELOAD_HI), reload_shadow[t][15:8], "reload high kept");
        end
        end_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: src/io_decoder.sv
`timescale 1ns/10ps

`include "io_settings.svh"

module io_decoder
    import io_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  bus_addr_t adr_i,
    input  logic      stb_i,
    output dev_sel_t  dev_stb_o,
    output logic      miss_ack_o,
    output logic      miss_o
);

    logic       in_window;
    logic [2:0] dev_idx;
    logic       dev_hit;
    logic       miss_access;
    logic       miss_ack_q;
    logic       miss_held_q;

    assign in_window = (adr_i[31:11] == `IO_WINDOW);
    assign dev_idx   = adr_i[10:8];
    assign dev_hit   = in_window && (int'(dev_idx) < `TIMER_COUNT);

    // per-timer strobe from bits 10:8
    always_comb begin
        dev_stb_o = '0;
        for (int i = 0; i < `TIMER_COUNT; i++) begin
            dev_stb_o[i] = stb_i && dev_hit && (int'(dev_idx) == i);
        end
    end

    // outside the window or an empty slot
    assign miss_o = stb_i && !dev_hit;

    // answer once per strobe, rearm after stb drops
    assign miss_access = miss_o && !miss_ack_q && !miss_held_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            miss_ack_q  <= 1'b0;
            miss_held_q <= 1'b0;
        end else begin
            miss_ack_q  <= miss_access;
            miss_held_q <= miss_o && (miss_held_q || miss_ack_q);
        end
    end

    assign miss_ack_o = miss_ack_q;

    dev_sel_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $onehot0(dev_stb_o) && !(miss_o && (|dev_stb_o))
    ) else $error("decoder selected more than one target");

endmodule

// File: src/io_fabric.sv
`timescale 1ns/10ps

`include "io_settings.svh"

module io_fabric
    import io_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  bus_addr_t adr_i,
    input  bus_data_t dat_i,
    input  logic      we_i,
    input  logic      stb_i,
    output bus_data_t dat_o,
    output logic      ack_o,
    output logic      irq_o
);

    dev_sel_t                     dev_stb;
    dev_sel_t                     dev_ack;
    dev_sel_t                     dev_irq;
    bus_data_t [`TIMER_COUNT-1:0] dev_dat;
    logic                         miss_ack;

    io_decoder u_decoder (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .adr_i      (adr_i),
        .stb_i      (stb_i),
        .dev_stb_o  (dev_stb),
        .miss_ack_o (miss_ack),
        .miss_o     ()
    );

    // one timer per device slot, 0xFFFFF800 upwards
    for (genvar i = 0; i < `TIMER_COUNT; i++) begin : g_timer
        timer_wb8 u_timer (
            .clk      (clk),
            .arst_n_i (arst_n_i),
            .stb_i    (dev_stb[i]),
            .we_i     (we_i),
            .adr_i    (timer_reg_e'(adr_i[2:0])),
            .dat_i    (dat_i),
            .dat_o    (dev_dat[i]),
            .ack_o    (dev_ack[i]),
            .irq_o    (dev_irq[i])
        );
    end

    io_resp_mux u_resp_mux (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .dev_ack_i  (dev_ack),
        .dev_dat_i  (dev_dat),
        .dev_irq_i  (dev_irq),
        .miss_ack_i (miss_ack),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .irq_o      (irq_o)
    );

endmodule

// File: src/io_pkg.sv
package io_pkg;

`include "io_settings.svh"

    // bus payloads
    typedef logic [`IO_DATA_W-1:0] bus_data_t;
    typedef logic [`IO_ADDR_W-1:0] bus_addr_t;

    // one bit per timer slot
    typedef logic [`TIMER_COUNT-1:0] dev_sel_t;

    // timer register map, low three address bits
    // CTRL: bit 0 enable, bit 1 auto-reload, bit 2 irq enable
    // STATUS: bit 0 pending, write 1 to clear
    // offsets 6 and 7 read as zero
    typedef enum logic [2:0] {
        CTRL      = 3'd0,
        RELOAD_LO = 3'd1,
        RELOAD_HI = 3'd2,
        COUNT_LO  = 3'd3,
        COUNT_HI  = 3'd4,
        STATUS    = 3'd5
    } timer_reg_e;

endpackage

// File: src/io_resp_mux.sv
`timescale 1ns/10ps

`include "io_settings.svh"

module io_resp_mux
    import io_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  dev_sel_t                     dev_ack_i,
    input  bus_data_t [`TIMER_COUNT-1:0] dev_dat_i,
    input  dev_sel_t                     dev_irq_i,
    input  logic                         miss_ack_i,
    output bus_data_t                    dat_o,
    output logic                         ack_o,
    output logic                         irq_o
);

    logic irq_q;

    // data from whichever source acknowledges
    always_comb begin
        dat_o = '0;
        for (int i = 0; i < `TIMER_COUNT; i++) begin
            if (dev_ack_i[i]) begin
                dat_o = dev_dat_i[i];
            end
        end
        if (miss_ack_i) begin
            dat_o = `IO_MISS_DATA;
        end
    end

    assign ack_o = (|dev_ack_i) || miss_ack_i;

    // level interrupt, one clock behind the timers
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |dev_irq_i;
        end
    end

    assign irq_o = irq_q;

    single_ack_source: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $onehot0({miss_ack_i, dev_ack_i})
    ) else $error("more than one acknowledge on the bus");

endmodule

// File: src/io_settings.svh
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// bus widths
`define IO_DATA_W 8
`define IO_ADDR_W 32

// number of timer slots in the I/O window, at most 8
`define TIMER_COUNT 4

// address bits 31:11 of the I/O window, 0xFFFFF800 and up
`define IO_WINDOW 21'h1F_FFFF

// read value for accesses that hit no device
`define IO_MISS_DATA 8'hFF

`endif

// File: src/timer_wb8.sv
`timescale 1ns/10ps

module timer_wb8
    import io_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  timer_reg_e adr_i,
    input  bus_data_t  dat_i,
    output bus_data_t  dat_o,
    output logic       ack_o,
    output logic       irq_o
);

    localparam int CNT_W = 16;

    logic             ctrl_en;
    logic             ctrl_auto;
    logic             ctrl_ie;
    logic [CNT_W-1:0] reload;
    logic [CNT_W-1:0] count;
    logic             pending;
    logic             ack_q;
    logic             held_q;
    logic             access;
    logic             wr;
    logic             expire;
    logic             clr_pending;
    bus_data_t        rd_mux;
    bus_data_t        rd_q;

    // one accepted access per strobe
    assign access = stb_i && !ack_q && !held_q;
    assign wr     = access && we_i;

    // last decrement or a zero count while running
    assign expire = ctrl_en && (count <= CNT_W'(1));

    assign clr_pending = wr && (adr_i == STATUS) && dat_i[0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            held_q <= 1'b0;
        end else begin
            ack_q  <= access;
            held_q <= stb_i && (held_q || ack_q);
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_en   <= 1'b0;
            ctrl_auto <= 1'b0;
            ctrl_ie   <= 1'b0;
            reload    <= '0;
            count     <= '0;
            pending   <= 1'b0;
        end else begin
            if (expire) begin
                if (ctrl_auto) begin
                    count <= reload;
                end else begin
                    count   <= '0;
                    ctrl_en <= 1'b0;
                end
            end else if (ctrl_en) begin
                count <= count - CNT_W'(1);
            end

            // a new expiry beats a clear in the same cycle
            pending <= expire || (pending && !clr_pending);

            // bus writes override the counter
            if (wr) begin
                case (adr_i)
                    CTRL: begin
                        ctrl_en   <= dat_i[0];
                        ctrl_auto <= dat_i[1];
                        ctrl_ie   <= dat_i[2];
                        if (dat_i[0]) begin
                            count <= reload;
                        end
                    end
                    RELOAD_LO: reload[7:0]  <= dat_i;
                    RELOAD_HI: reload[15:8] <= dat_i;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (adr_i)
            CTRL:      rd_mux = bus_data_t'({ctrl_ie, ctrl_auto, ctrl_en});
            RELOAD_LO: rd_mux = reload[7:0];
            RELOAD_HI: rd_mux = reload[15:8];
            COUNT_LO:  rd_mux = count[7:0];
            COUNT_HI:  rd_mux = count[15:8];
            STATUS:    rd_mux = bus_data_t'(pending);
            default:   rd_mux = '0;
        endcase
    end

    // captured with the strobe, shown during ack
    always_ff @(posedge clk) begin
        if (access) begin
            rd_q <= rd_mux;
        end
    end

    assign dat_o = rd_q;
    assign ack_o = ack_q;
    assign irq_o = pending && ctrl_ie;

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_o |=> !ack_o
    ) else $error("timer ack held for two cycles");

    ack_after_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_o |-> $past(stb_i)
    ) else $error("timer ack without a preceding strobe");

endmodule

// File: verilog.f
+incdir+src
src/io_pkg.sv
src/io_decoder.sv
src/timer_wb8.sv
src/io_resp_mux.sv
src/io_fabric.sv
sim/tb_io_fabric.sv
